// ==== Bender.yml ====
package:
  name: snd_board

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/snd_pkg.sv
      - hw/snd_bus_decode.sv
      - hw/snd_voice.sv
      - hw/snd_mixer.sv
      - hw/snd_board.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/snd_board_tb.sv

// ==== bench/snd_board_tb.sv ====
`default_nettype none

`include "snd_settings.svh"

module snd_board_tb;

    timeunit 1ns;
    timeprecision 1ps;

    logic                        clk;
    logic                        rst;
    logic                        psel;
    logic                        penable;
    logic                        pwrite;
    logic [7:0]                  paddr;
    logic [`WORD_W-1:0]          pwdata;
    logic [`WORD_W-1:0]          prdata;
    logic                        pready;
    logic                        pslverr;
    snd_pkg::cabinet_t [1:0]     cabinet;
    logic signed [`SAMPLE_W-1:0] snd;

    // register mirror, indexed [voice][kind]
    snd_pkg::voice_word_u model_regs [`NUM_VOICES][3];
    logic [31:0]          rng;
    int                   n_pass;
    int                   n_fail;

    snd_board snd_board_i (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng = rng * 32'd1664525 + 32'd1013904223;
        // low LCG bits repeat quickly
        return {8'd0, rng[31:8]};
    endfunction

    // word as the voice keeps it, reserved bits dropped
    function automatic snd_pkg::voice_word_u stored_word(input int k, input logic [15:0] d);
        snd_pkg::voice_word_u w;
        w = '0;
        case (k)
            0: w.period.period = d[`PERIOD_W-1:0];
            1: begin
                w.ctrl.enable = d[15];
                w.ctrl.volume = d[7:0];
            end
            default: w = {8'h00, d[7:0]};
        endcase
        return w;
    endfunction

    // bit k of neg_mask set means voice k is in its negative half
    function automatic logic signed [15:0] mix_expected(input int neg_mask);
        int sum;
        int lvl;
        sum = 0;
        for (int v = 0; v < `NUM_VOICES; v++) begin
            lvl = 0;
            if (model_regs[v][1].ctrl.enable) begin
                lvl = model_regs[v][1].ctrl.volume * 128;
            end
            if (neg_mask[v]) begin
                lvl = -lvl;
            end
            sum += lvl * int'(model_regs[v][2][7:0]);
        end
        sum = sum >>> 4;
        if (sum > 32767) begin
            sum = 32767;
        end else if (sum < -32768) begin
            sum = -32768;
        end
        return 16'(sum);
    endfunction

    // phases are unknown, so any sign combination is allowed
    function automatic logic signed [15:0] pick_mix(input logic signed [15:0] s);
        for (int m = 0; m < (1 << `NUM_VOICES); m++) begin
            if (mix_expected(m) == s) begin
                return mix_expected(m);
            end
        end
        return mix_expected(0);
    endfunction

    function automatic logic [15:0] cab_word(input snd_pkg::cabinet_t c);
        logic [15:0] w;
        w = 16'hFF40;
        w[7] = c.start;
        w[5] = c.joy[5];
        w[4] = c.joy[4];
        w[3] = c.joy[2];
        w[2] = c.joy[3];
        w[1] = c.joy[0];
        w[0] = c.joy[1];
        return w;
    endfunction

    task automatic check_word(input snd_pkg::voice_word_u got, exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s read %h, expected %h", $time, what, got, exp);
            n_fail++;
        end else begin
            n_pass++;
        end
    endtask

    task automatic check_snd(input logic signed [15:0] got, exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
            n_fail++;
        end else begin
            n_pass++;
        end
    endtask

    task automatic check_flag(input logic got, exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
            n_fail++;
        end else begin
            n_pass++;
        end
    endtask

    task automatic check_count(input int got, exp, input string what);
        if (got != exp) begin
            $display("[ERROR] %0t: %s is %0d cycles, expected %0d", $time, what, got, exp);
            n_fail++;
        end else begin
            n_pass++;
        end
    endtask

    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [15:0] wdata,
                            output logic [15:0] rdata, output logic err);
        int n;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        n = 0;
        @(negedge clk);
        check_flag(pready, 1'b1, "pready in access cycle");
        while (!pready && n < 16) begin
            @(negedge clk);
            n++;
        end
        if (!pready) begin
            $display("timeout: no pready for the transfer to address %h", addr);
            n_fail++;
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic reg_write(input int v, input int k, input logic [15:0] d);
        logic [15:0] rd;
        logic        err;
        apb_xfer(1'b1, {v[3:0], k[1:0], 2'b00}, d, rd, err);
        check_flag(err, 1'b0, "pslverr on voice write");
        model_regs[v][k] = stored_word(k, d);
    endtask

    task automatic check_all_regs(input string what);
        logic [15:0] rd;
        logic        err;
        for (int v = 0; v < `NUM_VOICES; v++) begin
            for (int k = 0; k < 3; k++) begin
                apb_xfer(1'b0, {v[3:0], k[1:0], 2'b00}, 16'h0000, rd, err);
                check_flag(err, 1'b0, "pslverr on voice read");
                check_word(rd, model_regs[v][k], what);
            end
        end
    endtask

    task automatic wait_snd(input logic signed [15:0] exp, input int limit, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (snd !== exp && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (snd !== exp) begin
            $display("timeout: snd never settled to %0d during %s", exp, what);
            n_fail++;
        end
    endtask

    task automatic report_test(input string name, input int fails_before);
        $display("test %s: %s (%0d errors)", name,
                 (n_fail == fails_before) ? "ok" : "failed", n_fail - fails_before);
    endtask

    initial begin
        int                 first;
        int                 tv;
        int                 p;
        int                 vol;
        int                 len;
        int                 slot;
        logic signed [15:0] plus;
        logic signed [15:0] minus;
        logic signed [15:0] prev;
        logic [15:0]        rd;
        logic               err;

        clk     = 1'b0;
        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        cabinet = '0;
        rng     = 32'h250e5899;
        n_pass  = 0;
        n_fail  = 0;
        for (int v = 0; v < `NUM_VOICES; v++) begin
            model_regs[v][0] = '0;
            model_regs[v][1] = '0;
            model_regs[v][2] = 16'h0010;
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        first = n_fail;
        @(negedge clk);
        check_snd(snd, 16'sd0, "snd after reset");
        check_flag(pslverr, 1'b0, "idle pslverr");
        check_word(prdata, 16'h0000, "idle prdata");
        check_all_regs("reset value");
        for (int i = 0; i < 40; i++) begin
            tv = next_rand() % `NUM_VOICES;
            p  = next_rand() % 3;
            reg_write(tv, p, 16'(next_rand()));
            apb_xfer(1'b0, {tv[3:0], p[1:0], 2'b00}, 16'h0000, rd, err);
            check_word(rd, model_regs[tv][p], "random readback");
        end
        report_test("reset_readback", first);

        first = n_fail;
        for (int i = 0; i < 6; i++) begin
            slot = `NUM_VOICES + next_rand() % (15 - `NUM_VOICES);
            apb_xfer(next_rand() % 2 == 1, {4'(slot), 2'(next_rand() % 3), 2'b00},
                     16'(next_rand()), rd, err);
            check_flag(err, 1'b1, "pslverr for voice out of range");
        end
        for (int v = 0; v < `NUM_VOICES; v++) begin
            apb_xfer(1'b1, {4'(v), 2'd3, 2'b00}, 16'hFFFF, rd, err);
            check_flag(err, 1'b1, "pslverr on kind 3 write");
            apb_xfer(1'b0, {4'(v), 2'd3, 2'b00}, 16'h0000, rd, err);
            check_flag(err, 1'b1, "pslverr on kind 3 read");
        end
        apb_xfer(1'b1, 8'hF0, 16'hFFFF, rd, err);
        check_flag(err, 1'b1, "pslverr on cabinet write");
        check_all_regs("register after bad access");
        report_test("address_errors", first);

        first = n_fail;
        for (int i = 0; i < 20; i++) begin
            @(posedge clk);
            cabinet <= 14'(next_rand());
            // let the decoder sample the new inputs
            for (int c = 0; c < 4; c++) begin
                @(posedge clk);
            end
            for (int pl = 0; pl < 2; pl++) begin
                apb_xfer(1'b0, 8'hF0 | 8'(pl * 4), 16'h0000, rd, err);
                check_flag(err, 1'b0, "pslverr on cabinet read");
                check_word(rd, cab_word(cabinet[pl]), "cabinet port");
            end
        end
        report_test("cabinet_remap", first);

        first = n_fail;
        tv  = next_rand() % `NUM_VOICES;
        p   = 2 + next_rand() % 40;
        vol = 1 + next_rand() % 255;
        for (int v = 0; v < `NUM_VOICES; v++) begin
            reg_write(v, 1, 16'h0000);
            reg_write(v, 2, 16'h0010);
        end
        reg_write(tv, 0, 16'(p));
        reg_write(tv, 1, 16'h8000 | 16'(vol));
        plus  = mix_expected(0);
        minus = mix_expected(-1);
        wait_snd(plus, 8, "tone start");
        prev = snd;
        for (int r = 0; r < 5; r++) begin
            len = 0;
            do begin
                @(negedge clk);
                len++;
            end while (snd == prev && len <= 2 * p + 8);
            if (snd == prev) begin
                $display("timeout: snd stopped toggling on voice %0d", tv);
                n_fail++;
                break;
            end
            check_snd(snd, (prev == plus) ? minus : plus, "tone level");
            // the run before the first sign change includes the start-up
            if (r > 0) begin
                check_count(len, p + 1, "tone half period");
            end
            prev = snd;
        end
        report_test("tone_period", first);

        first = n_fail;
        for (int i = 0; i < 15; i++) begin
            for (int v = 0; v < `NUM_VOICES; v++) begin
                reg_write(v, 0, 16'(next_rand() % 64));
                reg_write(v, 2, 16'(next_rand()));
                reg_write(v, 1, 16'(next_rand()) & 16'h80FF);
            end
            // longer than the longest period used here
            for (int c = 0; c < 70; c++) begin
                @(negedge clk);
            end
            for (int c = 0; c < 8; c++) begin
                @(negedge clk);
                check_snd(snd, pick_mix(snd), "mixed output");
            end
        end
        // all voices start positive and stay there for 4096 cycles
        for (int v = 0; v < `NUM_VOICES; v++) begin
            reg_write(v, 0, 16'hFFFF);
            reg_write(v, 2, 16'h00F0);
        end
        for (int v = 0; v < `NUM_VOICES; v++) begin
            reg_write(v, 1, 16'h80FF);
        end
        wait_snd(mix_expected(0), 8, "saturation");
        check_snd(snd, 16'sh7FFF, "saturated output");
        report_test("mix_saturation", first);

        first = n_fail;
        for (int v = 0; v < `NUM_VOICES; v++) begin
            reg_write(v, 1, 16'(next_rand()) & 16'h00FF);
        end
        wait_snd(mix_expected(0), 2, "disable");
        for (int c = 0; c < 200; c++) begin
            @(negedge clk);
            check_snd(snd, mix_expected(0), "snd after disable");
        end
        report_test("disable", first);

        $display("checks passed %0d, failed %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/snd_board.sv ====
`default_nettype none

`include "snd_settings.svh"

module snd_board (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    psel,
    input  wire logic                    penable,
    input  wire logic                    pwrite,
    input  wire logic [7:0]              paddr,
    input  wire logic [`WORD_W-1:0]      pwdata,
    output logic [`WORD_W-1:0]           prdata,
    output logic                         pready,
    output logic                         pslverr,
    input  wire snd_pkg::cabinet_t [1:0] cabinet,
    output logic signed [`SAMPLE_W-1:0]  snd
);

    snd_pkg::voice_wr_t                         voice_wr;
    snd_pkg::voice_word_u [`NUM_VOICES-1:0][2:0] voice_regs;
    snd_pkg::voice_out_t  [`NUM_VOICES-1:0]      voice_outs;

    snd_bus_decode snd_bus_decode_i (
        .clk        (clk),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .cabinet    (cabinet),
        .voice_regs (voice_regs),
        .voice_wr   (voice_wr)
    );

    // identical voices, each answers to its own slot
    for (genvar v = 0; v < `NUM_VOICES; v++) begin : g_voice
        snd_voice #(
            .voice_id (v)
        ) snd_voice_i (
            .clk       (clk),
            .rst       (rst),
            .voice_wr  (voice_wr),
            .regs      (voice_regs[v]),
            .voice_out (voice_outs[v])
        );
    end

    snd_mixer snd_mixer_i (
        .clk    (clk),
        .rst    (rst),
        .voices (voice_outs),
        .snd    (snd)
    );

endmodule

`default_nettype wire

// ==== hw/snd_bus_decode.sv ====
`default_nettype none

`include "snd_settings.svh"

module snd_bus_decode (
    input  wire logic                                     clk,
    input  wire logic                                     rst,
    input  wire logic                                     psel,
    input  wire logic                                     penable,
    input  wire logic                                     pwrite,
    input  wire logic [7:0]                               paddr,
    input  wire logic [`WORD_W-1:0]                       pwdata,
    output logic [`WORD_W-1:0]                            prdata,
    output logic                                          pready,
    output logic                                          pslverr,
    input  wire snd_pkg::cabinet_t [1:0]                  cabinet,
    input  wire snd_pkg::voice_word_u [`NUM_VOICES-1:0][2:0] voice_regs,
    output snd_pkg::voice_wr_t                            voice_wr
);

    logic                    access;
    logic [3:0]              slot;
    logic [1:0]              kind;
    logic                    voice_hit;
    logic                    cab_hit;
    logic                    legal;
    snd_pkg::cabinet_t [1:0] cab_q;
    snd_pkg::voice_word_u    rd_word;
    logic [7:0]              cab_byte;

    // original harness wiring of the joystick bits
    function automatic logic [7:0] cab_remap(input snd_pkg::cabinet_t c);
        return {c.start, 1'b1, c.joy[5:4], c.joy[2], c.joy[3], c.joy[0], c.joy[1]};
    endfunction

    assign access = psel & penable;
    assign slot   = paddr[7:4];
    assign kind   = paddr[3:2];

    // voice slots sit below 0xF0, kind 3 left unmapped
    assign voice_hit = (slot < 4'(`NUM_VOICES)) && (kind != 2'd3);

    // 0xF0 player 1, 0xF4 player 2
    assign cab_hit = (paddr[7:3] == 5'b11110);

    // cabinet ports are read only
    assign legal = voice_hit | (cab_hit & ~pwrite);

    // no wait states
    assign pready  = access;
    assign pslverr = access & ~legal;

    // sampled every clock
    always_ff @(posedge clk) begin
        if (rst) begin
            cab_q <= '0;
        end else begin
            cab_q <= cabinet;
        end
    end

    assign cab_byte = cab_remap(cab_q[paddr[2]]);

    // readback word from the addressed voice
    always_comb begin
        rd_word = '0;
        for (int v = 0; v < `NUM_VOICES; v++) begin
            if ((slot == 4'(v)) && (kind != 2'd3)) begin
                rd_word = voice_regs[v][kind];
            end
        end
    end

    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            if (voice_hit) begin
                prdata = rd_word;
            end else if (cab_hit) begin
                prdata = {8'hFF, cab_byte};
            end
        end
    end

    // one broadcast for all voices, each voice matches its own index
    always_comb begin
        voice_wr       = '0;
        voice_wr.valid = access & pwrite & voice_hit;
        voice_wr.idx   = paddr[4+`VOICE_IDX_W-1:4];
        voice_wr.kind  = snd_pkg::voice_reg_e'(kind);
        voice_wr.word  = pwdata;
    end

endmodule

`default_nettype wire

// ==== hw/snd_mixer.sv ====
`default_nettype none

`include "snd_settings.svh"

module snd_mixer (
    input  wire logic                               clk,
    input  wire logic                               rst,
    input  wire snd_pkg::voice_out_t [`NUM_VOICES-1:0] voices,
    output logic signed [`SAMPLE_W-1:0]             snd
);

    // sample times a zero-extended gain
    localparam int PROD_W = `SAMPLE_W + `GAIN_W + 1;
    // headroom for the sum of all voices
    localparam int SUM_W  = PROD_W + $clog2(`NUM_VOICES) + 1;

    localparam logic signed [SUM_W-1:0] SAT_MAX = SUM_W'((2 ** (`SAMPLE_W - 1)) - 1);
    localparam logic signed [SUM_W-1:0] SAT_MIN = -SUM_W'(2 ** (`SAMPLE_W - 1));

    logic signed [PROD_W-1:0]    prod [`NUM_VOICES];
    logic signed [SUM_W-1:0]     acc;
    logic signed [SUM_W-1:0]     scaled;
    logic signed [`SAMPLE_W-1:0] clamped;

    always_comb begin
        for (int v = 0; v < `NUM_VOICES; v++) begin
            prod[v] = $signed(voices[v].sample) * $signed({1'b0, voices[v].gain});
        end
    end

    // full width sum, no overflow possible
    always_comb begin
        acc = '0;
        for (int v = 0; v < `NUM_VOICES; v++) begin
            acc = acc + SUM_W'(prod[v]);
        end
    end

    // drop the 4 fraction bits of the gain
    assign scaled = acc >>> 4;

    always_comb begin
        if (scaled > SAT_MAX) begin
            clamped = SAT_MAX[`SAMPLE_W-1:0];
        end else if (scaled < SAT_MIN) begin
            clamped = SAT_MIN[`SAMPLE_W-1:0];
        end else begin
            clamped = scaled[`SAMPLE_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            snd <= '0;
        end else begin
            snd <= clamped;
        end
    end

endmodule

`default_nettype wire

// ==== hw/snd_pkg.sv ====
`default_nettype none

`include "snd_settings.svh"

package snd_pkg;

    // period register view
    typedef struct packed {
        logic [`WORD_W-`PERIOD_W-1:0] rsvd;
        logic [`PERIOD_W-1:0]         period;
    } period_view_t;

    // control register view
    typedef struct packed {
        logic                         enable;
        logic [`WORD_W-`VOLUME_W-2:0] rsvd;
        logic [`VOLUME_W-1:0]         volume;
    } ctrl_view_t;

    // same 16 bits, meaning set by the register address
    typedef union packed {
        period_view_t period;
        ctrl_view_t   ctrl;
    } voice_word_u;

    // register within a voice slot, kind 3 is unmapped
    typedef enum logic [1:0] {
        REG_PERIOD = 2'd0,
        REG_CTRL   = 2'd1,
        REG_GAIN   = 2'd2
    } voice_reg_e;

    typedef struct packed {
        logic                    valid;
        logic [`VOICE_IDX_W-1:0] idx;
        voice_reg_e              kind;
        voice_word_u             word;
    } voice_wr_t;

    typedef struct packed {
        logic signed [`SAMPLE_W-1:0] sample;
        logic [`GAIN_W-1:0]          gain;
    } voice_out_t;

    // one per player
    typedef struct packed {
        logic [5:0] joy;
        logic       start;
    } cabinet_t;

endpackage

`default_nettype wire

// ==== hw/snd_settings.svh ====
`ifndef SND_SETTINGS_SVH
`define SND_SETTINGS_SVH

// number of identical tone voices, 1 to 8
`define NUM_VOICES 2

// width of the voice index carried on the write broadcast
`define VOICE_IDX_W 3

// half-period counter width, in clk cycles
`define PERIOD_W 12

// signed audio sample width
`define SAMPLE_W 16

// 4.4 fixed point gain
`define GAIN_W 8

// unsigned voice volume
`define VOLUME_W 8

// host data word
`define WORD_W 16

`endif

// ==== hw/snd_voice.sv ====
`default_nettype none

`include "snd_settings.svh"

module snd_voice #(
    parameter int voice_id = 0
) (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire snd_pkg::voice_wr_t        voice_wr,
    output snd_pkg::voice_word_u [2:0]     regs,
    output snd_pkg::voice_out_t            voice_out
);

    logic                        hit;
    logic                        restart;
    logic [`WORD_W-1:0]          wr_bits;
    logic [`PERIOD_W-1:0]        period_q;
    logic                        enable_q;
    logic [`VOLUME_W-1:0]        volume_q;
    logic [`GAIN_W-1:0]          gain_q;
    logic [`PERIOD_W-1:0]        cnt_q;
    logic                        phase_q;
    logic signed [`SAMPLE_W-1:0] sample_q;
    logic signed [`SAMPLE_W-1:0] level;

    assign hit     = voice_wr.valid && (voice_wr.idx == `VOICE_IDX_W'(voice_id));
    assign restart = hit && (voice_wr.kind != snd_pkg::REG_GAIN);
    assign wr_bits = voice_wr.word;

    always_ff @(posedge clk) begin
        if (rst) begin
            period_q <= '0;
            enable_q <= 1'b0;
            volume_q <= '0;
            gain_q   <= `GAIN_W'(8'h10);
        end else if (hit) begin
            case (voice_wr.kind)
                snd_pkg::REG_PERIOD: period_q <= voice_wr.word.period.period;
                snd_pkg::REG_CTRL: begin
                    enable_q <= voice_wr.word.ctrl.enable;
                    volume_q <= voice_wr.word.ctrl.volume;
                end
                snd_pkg::REG_GAIN: gain_q <= wr_bits[`GAIN_W-1:0];
                default: ;
            endcase
        end
    end

    // half-period counter, phase flips when it reaches the period
    always_ff @(posedge clk) begin
        if (rst || restart) begin
            cnt_q   <= '0;
            phase_q <= 1'b1;
        end else if (enable_q) begin
            if (cnt_q == period_q) begin
                cnt_q   <= '0;
                phase_q <= ~phase_q;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    // volume scaled to the top of the sample range
    assign level = $signed({1'b0, volume_q, 7'd0});

    always_ff @(posedge clk) begin
        if (rst) begin
            sample_q <= '0;
        end else begin
            sample_q <= !enable_q ? '0 : (phase_q ? level : -level);
        end
    end

    always_comb begin
        regs = '0;
        regs[0].period.period = period_q;
        regs[1].ctrl.enable   = enable_q;
        regs[1].ctrl.volume   = volume_q;
        regs[2]               = {{(`WORD_W-`GAIN_W){1'b0}}, gain_q};
    end

    assign voice_out.sample = sample_q;
    assign voice_out.gain   = gain_q;

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+hw
hw/snd_pkg.sv
hw/snd_bus_decode.sv
hw/snd_voice.sv
hw/snd_mixer.sv
hw/snd_board.sv
bench/snd_board_tb.sv
